/* Bender.yml */
package:
  name: ahb_fir_slave

sources:
  - files:
      - hw/fir_bus_pkg.sv
      - hw/ahb_addr_phase.sv
      - hw/fir_reg_file.sv
      - hw/ahb_response.sv
      - hw/ahb_fir_slave.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_ahb_fir_slave.sv

/* ahb_fir_slave.f */
+incdir+testbench
hw/fir_bus_pkg.sv
hw/ahb_addr_phase.sv
hw/fir_reg_file.sv
hw/ahb_response.sv
hw/ahb_fir_slave.sv
testbench/tb_ahb_fir_slave.sv

/* hw/ahb_addr_phase.sv */
/* Address phase stage: decodes hsel, htrans, haddr, hsize and hwrite at each rising
   edge into the request that the data phase stages act on in the next cycle. */

`timescale 1ns/1ps

module ahb_addr_phase (
  input  logic                              tb_clk,
  input  logic                              rst,
  input  logic                              hsel,
  input  logic [1:0]                        htrans,
  input  logic [fir_bus_pkg::ADDR_WIDTH-1:0] haddr,
  input  logic                              hsize,
  input  logic                              hwrite,
  output fir_bus_pkg::ahb_req_t             req
);

  import fir_bus_pkg::*;

  // Halfword aligned address, picks the register
  logic [ADDR_WIDTH-1:0] hw_addr;
  logic                  active;
  // Error terms
  logic                  wr_read_only;
  logic                  top_byte;
  logic                  misaligned;
  ahb_req_t              req_d;

  // ****************************************
  // Decode
  // ****************************************

  assign hw_addr = {haddr[ADDR_WIDTH-1:1], 1'b0};

  // Only NONSEQ and SEQ move data
  assign active = hsel && ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  // Status and result live below the sample register
  assign wr_read_only = hwrite && (hw_addr < ADDR_SAMPLE);
  // Upper byte of the set register is not mapped
  assign top_byte     = (haddr == {ADDR_WIDTH{1'b1}});
  // Halfwords must sit on an even address
  assign misaligned   = hsize && haddr[0];

  always_comb begin
    req_d.valid     = active;
    req_d.write     = hwrite;
    // hsize bit 0 is 1 for a halfword
    req_d.byte_size = ~hsize;
    req_d.high_lane = haddr[0];
    req_d.bad       = active && (wr_read_only || top_byte || misaligned);

    unique case (hw_addr)
      ADDR_STATUS:          req_d.reg_sel = REG_STATUS;
      ADDR_RESULT:          req_d.reg_sel = REG_RESULT;
      ADDR_SAMPLE:          req_d.reg_sel = REG_SAMPLE;
      ADDR_COEF_START:      req_d.reg_sel = REG_COEF0;
      ADDR_COEF_START + 2:  req_d.reg_sel = REG_COEF1;
      ADDR_COEF_START + 4:  req_d.reg_sel = REG_COEF2;
      ADDR_COEF_START + 6:  req_d.reg_sel = REG_COEF3;
      ADDR_COEF_SET:        req_d.reg_sel = REG_COEF_SET;
      default:              req_d.reg_sel = REG_NONE;
    endcase

    // Idle cycles select nothing so the read mux returns zero
    if (!active) begin
      req_d.reg_sel = REG_NONE;
    end
  end

  // ****************************************
  // Data phase request register
  // ****************************************

  // No wait states, so a new request is taken every cycle
  always_ff @(posedge tb_clk) begin
    if (rst) begin
      req.valid     <= 1'b0;
      req.write     <= 1'b0;
      req.reg_sel   <= REG_NONE;
      req.byte_size <= 1'b0;
      req.high_lane <= 1'b0;
      req.bad       <= 1'b0;
    end else begin
      req <= req_d;
    end
  end

  // Aligned halfword accesses to a coefficient are always legal,
  // whatever the direction
  assert property (@(posedge tb_clk) disable iff (rst)
    (req.valid && !req.byte_size && !req.high_lane &&
     (req.reg_sel inside {REG_COEF0, REG_COEF1, REG_COEF2, REG_COEF3}))
    |-> !req.bad)
    else $error("Aligned coefficient access flagged as bad");

endmodule

/* hw/ahb_fir_slave.sv */
/* Top level of the AHB-Lite FIR slave, joining the address phase, register file and
   response stages between the bus and the FIR filter. */

`timescale 1ns/1ps

module ahb_fir_slave (
  input  logic                                       tb_clk,
  input  logic                                       rst,
  // AHB-Lite without hready
  input  logic                                       hsel,
  input  logic [1:0]                                 htrans,
  input  logic [fir_bus_pkg::ADDR_WIDTH-1:0]         haddr,
  input  logic                                       hsize,
  input  logic                                       hwrite,
  input  logic [fir_bus_pkg::DATA_WIDTH-1:0]         hwdata,
  output logic [fir_bus_pkg::DATA_WIDTH-1:0]         hrdata,
  output logic                                       hresp,
  // Filter side
  input  logic [fir_bus_pkg::DATA_WIDTH-1:0]         fir_out,
  input  logic                                       modwait,
  input  logic                                       err,
  input  logic [$clog2(fir_bus_pkg::NUM_COEFFS)-1:0] coefficient_num,
  output logic [fir_bus_pkg::DATA_WIDTH-1:0]         sample_data,
  output logic                                       data_ready,
  output logic [fir_bus_pkg::DATA_WIDTH-1:0]         fir_coefficient,
  output logic                                       new_coefficient_set
);

  import fir_bus_pkg::*;

  // Request held for the data phase
  ahb_req_t                              req;
  // Stored coefficients, read back on the bus
  logic [NUM_COEFFS-1:0][DATA_WIDTH-1:0] coeffs;

  // ****************************************
  // Stages
  // ****************************************

  ahb_addr_phase i_ahb_addr_phase (
    .tb_clk (tb_clk),
    .rst    (rst),
    .hsel   (hsel),
    .htrans (htrans),
    .haddr  (haddr),
    .hsize  (hsize),
    .hwrite (hwrite),
    .req    (req)
  );

  // Write word enters as the halfword view of the union
  fir_reg_file i_fir_reg_file (
    .tb_clk              (tb_clk),
    .rst                 (rst),
    .req                 (req),
    .hwdata              (hwdata),
    .modwait             (modwait),
    .coefficient_num     (coefficient_num),
    .sample_data         (sample_data),
    .data_ready          (data_ready),
    .coeffs              (coeffs),
    .new_coefficient_set (new_coefficient_set),
    .fir_coefficient     (fir_coefficient)
  );

  ahb_response i_ahb_response (
    .req                 (req),
    .sample_data         (sample_data),
    .coeffs              (coeffs),
    .new_coefficient_set (new_coefficient_set),
    .fir_out             (fir_out),
    .modwait             (modwait),
    .err                 (err),
    .hrdata              (hrdata),
    .hresp               (hresp)
  );

endmodule

/* hw/ahb_response.sv */
/* Data phase response: returns the register that the held request selects on hrdata
   and raises hresp for one cycle when that request is an error access. */

`timescale 1ns/1ps

module ahb_response (
  input  fir_bus_pkg::ahb_req_t                req,
  input  logic [fir_bus_pkg::DATA_WIDTH-1:0]   sample_data,
  input  logic [fir_bus_pkg::NUM_COEFFS-1:0][fir_bus_pkg::DATA_WIDTH-1:0] coeffs,
  input  logic                                 new_coefficient_set,
  input  logic [fir_bus_pkg::DATA_WIDTH-1:0]   fir_out,
  input  logic                                 modwait,
  input  logic                                 err,
  output logic [fir_bus_pkg::DATA_WIDTH-1:0]   hrdata,
  output logic                                 hresp
);

  import fir_bus_pkg::*;

  // Filter flags as the status register shows them
  logic [DATA_WIDTH-1:0] status_word;

  // ****************************************
  // Status word
  // ****************************************

  // Busy and error flags, all other bits read as zero
  always_comb begin
    status_word                  = '0;
    status_word[STATUS_BUSY_BIT] = modwait;
    status_word[STATUS_ERR_BIT]  = err;
  end

  // ****************************************
  // Read data
  // ****************************************

  // Whole halfword goes out, a byte read takes its own lane
  always_comb begin
    case (req.reg_sel)
      REG_STATUS:   hrdata = status_word;
      REG_RESULT:   hrdata = fir_out;
      REG_SAMPLE:   hrdata = sample_data;
      REG_COEF0:    hrdata = coeffs[0];
      REG_COEF1:    hrdata = coeffs[1];
      REG_COEF2:    hrdata = coeffs[2];
      REG_COEF3:    hrdata = coeffs[3];
      // Flag sits in bit 0
      REG_COEF_SET: hrdata = {{(DATA_WIDTH-1){1'b0}}, new_coefficient_set};
      // Idle, unselected or unmapped
      default:      hrdata = '0;
    endcase
  end

  // ****************************************
  // Error response
  // ****************************************

  // One-cycle error, high for the whole data phase of a bad request
  always_comb begin
    hresp = req.bad;
    // An error response belongs to a real transfer
    if (hresp) begin
      assert (req.valid)
        else $error("hresp raised without a valid request");
    end
  end

endmodule

/* hw/fir_bus_pkg.sv */
/* Shared address map, widths and bus request types for the AHB-Lite FIR slave.
   Imported by every RTL stage of the slave. */

package fir_bus_pkg;

  // ****************************************
  // Widths
  // ****************************************

  // One halfword data path, byte addressed map of 16 bytes
  localparam int DATA_WIDTH = 16;
  localparam int ADDR_WIDTH = 4;

  // Coefficient count fixed by the map, four halfwords from address 6
  localparam int NUM_COEFFS = 4;

  // ****************************************
  // Address map
  // ****************************************

  localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS     = 4'd0;
  localparam logic [ADDR_WIDTH-1:0] ADDR_RESULT     = 4'd2;
  localparam logic [ADDR_WIDTH-1:0] ADDR_SAMPLE     = 4'd4;
  // F0 here, F1 to F3 follow every two bytes
  localparam logic [ADDR_WIDTH-1:0] ADDR_COEF_START = 4'd6;
  localparam logic [ADDR_WIDTH-1:0] ADDR_COEF_SET   = 4'd14;

  // Status word bit positions
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_ERR_BIT  = 8;

  // Transfer codes that carry data, IDLE and BUSY are ignored
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // ****************************************
  // Request types
  // ****************************************

  // One select per register, plus none for idle or unselected cycles
  typedef enum logic [3:0] {
    REG_STATUS,
    REG_RESULT,
    REG_SAMPLE,
    REG_COEF0,
    REG_COEF1,
    REG_COEF2,
    REG_COEF3,
    REG_COEF_SET,
    REG_NONE
  } reg_sel_t;

  // Decoded address phase, held for the data phase
  typedef struct packed {
    logic     valid;
    logic     write;
    reg_sel_t reg_sel;
    // 1 for a byte, 0 for a halfword
    logic     byte_size;
    // Odd byte address, selects the upper lane
    logic     high_lane;
    logic     bad;
  } ahb_req_t;

  // Write word seen as a halfword or as two byte lanes
  typedef union packed {
    logic [DATA_WIDTH-1:0]  half;
    logic [1:0][7:0]        lane;
  } hwdata_u;

endpackage

/* hw/fir_reg_file.sv */
/* Register file of the slave: takes good data phase writes into the sample,
   coefficient and set-flag registers and drives the filter-side outputs. */

`timescale 1ns/1ps

module fir_reg_file (
  input  logic                                       tb_clk,
  input  logic                                       rst,
  input  fir_bus_pkg::ahb_req_t                      req,
  input  fir_bus_pkg::hwdata_u                       hwdata,
  input  logic                                       modwait,
  input  logic [$clog2(fir_bus_pkg::NUM_COEFFS)-1:0] coefficient_num,
  output logic [fir_bus_pkg::DATA_WIDTH-1:0]         sample_data,
  output logic                                       data_ready,
  output logic [fir_bus_pkg::NUM_COEFFS-1:0][fir_bus_pkg::DATA_WIDTH-1:0] coeffs,
  output logic                                       new_coefficient_set,
  output logic [fir_bus_pkg::DATA_WIDTH-1:0]         fir_coefficient
);

  import fir_bus_pkg::*;

  // Index of the last coefficient the loader asks for
  localparam int LAST_COEF = NUM_COEFFS - 1;

  logic wr_en;
  logic sample_wr;
  logic set_wr;
  // Loader has taken the last coefficient
  logic load_done;

  // ****************************************
  // Write strobes
  // ****************************************

  // Bad requests are dropped here, nothing changes
  assign wr_en     = req.valid && req.write && !req.bad;
  assign sample_wr = wr_en && (req.reg_sel == REG_SAMPLE);
  assign set_wr    = wr_en && (req.reg_sel == REG_COEF_SET);

  assign load_done = new_coefficient_set && (coefficient_num == LAST_COEF) && !modwait;

  // Byte writes replace only their own lane
  function automatic logic [DATA_WIDTH-1:0] merge_write(
    input hwdata_u old_val,
    input hwdata_u new_val,
    input logic    byte_size,
    input logic    high_lane
  );
    hwdata_u merged;
    merged = new_val;
    if (byte_size) begin
      merged = old_val;
      merged.lane[high_lane] = new_val.lane[high_lane];
    end
    return merged.half;
  endfunction

  // ****************************************
  // Sample register and ready pulse
  // ****************************************

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      sample_data <= '0;
      data_ready  <= 1'b0;
    end else begin
      // Pulse lasts the cycle after the write edge
      data_ready <= sample_wr;
      if (sample_wr) begin
        sample_data <= merge_write(sample_data, hwdata, req.byte_size, req.high_lane);
      end
    end
  end

  // ****************************************
  // Coefficients
  // ****************************************

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      coeffs <= '0;
    end else begin
      for (int i = 0; i < NUM_COEFFS; i++) begin
        // F0 to F3 are consecutive selects
        if (wr_en && (req.reg_sel == reg_sel_t'(REG_COEF0 + i))) begin
          coeffs[i] <= merge_write(coeffs[i], hwdata, req.byte_size, req.high_lane);
        end
      end
    end
  end

  // Loader reads its coefficient in the same cycle
  assign fir_coefficient = coeffs[coefficient_num];

  // ****************************************
  // Coefficient set flag
  // ****************************************

  always_ff @(posedge tb_clk) begin
    if (rst) begin
      new_coefficient_set <= 1'b0;
    end else if (set_wr) begin
      // Bus write wins over the loader clearing it
      new_coefficient_set <= hwdata.half[0];
    end else if (load_done) begin
      new_coefficient_set <= 1'b0;
    end
  end

  // Filter needs at least a cycle between samples, so the master
  // never writes the sample register in two data phases in a row
  assert property (@(posedge tb_clk) disable iff (rst)
    data_ready |=> !data_ready)
    else $error("data_ready held high for two cycles");

endmodule

/* testbench/tb_ahb_fir_tasks.svh */
/* Bus transfer, random data and filter-side drive tasks for the FIR slave testbench.
   Included inside the testbench module after its signal and model declarations. */

`ifndef TB_AHB_FIR_TASKS_SVH
`define TB_AHB_FIR_TASKS_SVH

// ****************************************
// Random data
// ****************************************

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

// One LFSR step per bit taken, msb first
function automatic logic [15:0] random_bits(input int nbits);
  logic [15:0] val;
  val = '0;
  for (int i = 0; i < nbits; i++) begin
    val        = {val[14:0], lfsr_state[31]};
    lfsr_state = lfsr_step(lfsr_state);
  end
  return val;
endfunction

// ****************************************
// Register map rules
// ****************************************

// Write to status or result, byte 15, or a halfword at an odd address
function automatic logic is_bad(input xfer_t t);
  return (t.write && (t.addr < 4'd4)) || (t.addr == 4'd15) || (!t.byte_sz && t.addr[0]);
endfunction

// Byte writes keep the other lane
function automatic logic [15:0] merge_lane(input logic [15:0] old_val, input xfer_t t);
  if (!t.byte_sz) begin
    return t.data;
  end
  if (t.addr[0]) begin
    return {t.data[15:8], old_val[7:0]};
  end
  return {old_val[15:8], t.data[7:0]};
endfunction

// Expected read word for the current model and filter inputs
function automatic logic [15:0] read_value(input logic [ADDR_WIDTH-1:0] addr);
  logic [15:0] val;
  val = '0;
  case (addr[3:1])
    3'd0: begin
      val[STATUS_BUSY_BIT] = modwait;
      val[STATUS_ERR_BIT]  = err;
    end
    3'd1: val = fir_out;
    3'd2: val = exp_sample;
    3'd3: val = exp_coef[0];
    3'd4: val = exp_coef[1];
    3'd5: val = exp_coef[2];
    3'd6: val = exp_coef[3];
    default: val[0] = exp_set;
  endcase
  return val;
endfunction

// ****************************************
// Bus cycle
// ****************************************

// One clock of the pipelined bus, from the falling edge
task automatic bus_step(input xfer_t next);
  logic set_next;
  logic ready_next;
  int   idx;
  @(negedge tb_clk);
  set_next   = exp_set;
  ready_next = 1'b0;
  // Loader took F3 while the filter was idle
  if (exp_set && (coefficient_num == 2'd3) && !modwait) begin
    set_next = 1'b0;
  end
  // Data phase that ended at the last rising edge has been written
  if (dphase.valid && dphase.write && !is_bad(dphase)) begin
    case (dphase.addr[3:1])
      3'd2: begin
        exp_sample = merge_lane(exp_sample, dphase);
        ready_next = 1'b1;
      end
      3'd3, 3'd4, 3'd5, 3'd6: begin
        idx           = int'(dphase.addr[3:1]) - 3;
        exp_coef[idx] = merge_lane(exp_coef[idx], dphase);
      end
      3'd7: set_next = dphase.data[0];
      default: ;
    endcase
  end
  exp_set   = set_next;
  exp_ready = ready_next;
  // Filter side changes with the bus
  coefficient_num = nxt_coef_num;
  modwait         = nxt_modwait;
  err             = nxt_err;
  fir_out         = nxt_fir_out;
  // Last address phase enters its data phase
  dphase     = aphase;
  hwdata     = dphase.data;
  exp_hresp  = dphase.valid && is_bad(dphase);
  chk_rdata  = dphase.valid && !dphase.write && !is_bad(dphase);
  exp_rdata  = read_value(dphase.addr);
  rdata_mask = !dphase.byte_sz ? 16'hffff : (dphase.addr[0] ? 16'hff00 : 16'h00ff);
  // New address phase
  aphase = next;
  hsel   = next.valid;
  htrans = next.valid ? HTRANS_NONSEQ : 2'b00;
  haddr  = next.addr;
  hsize  = !next.byte_sz;
  hwrite = next.write;
endtask

task automatic idle_cycles(input int n);
  xfer_t t;
  t = '0;
  repeat (n) begin
    bus_step(t);
  end
endtask

task automatic write_half(input logic [ADDR_WIDTH-1:0] addr, input logic [15:0] value);
  xfer_t t;
  t       = '0;
  t.valid = 1'b1;
  t.write = 1'b1;
  t.addr  = addr;
  t.data  = value;
  bus_step(t);
endtask

// Other lane carries noise that must not land
task automatic write_byte(input logic [ADDR_WIDTH-1:0] addr, input logic [7:0] value);
  xfer_t      t;
  logic [7:0] noise;
  noise     = 8'(random_bits(8));
  t         = '0;
  t.valid   = 1'b1;
  t.write   = 1'b1;
  t.byte_sz = 1'b1;
  t.addr    = addr;
  t.data    = addr[0] ? {value, noise} : {noise, value};
  bus_step(t);
endtask

task automatic read_xfer(input logic [ADDR_WIDTH-1:0] addr, input logic byte_sz);
  xfer_t t;
  t         = '0;
  t.valid   = 1'b1;
  t.byte_sz = byte_sz;
  t.addr    = addr;
  t.data    = random_bits(16);
  bus_step(t);
endtask

task automatic read_half(input logic [ADDR_WIDTH-1:0] addr);
  read_xfer(addr, 1'b0);
endtask

task automatic read_byte(input logic [ADDR_WIDTH-1:0] addr);
  read_xfer(addr, 1'b1);
endtask

// Filter-side values, applied at the next bus cycle
task automatic stage_filter(input logic [1:0] num, input logic mw, input logic e,
                            input logic [15:0] fo);
  nxt_coef_num = num;
  nxt_modwait  = mw;
  nxt_err      = e;
  nxt_fir_out  = fo;
endtask

`endif

/* testbench/tb_ahb_fir_slave.sv */
/* Testbench for the AHB-Lite FIR slave: drives bus and filter-side tests and checks the
   outputs against a register map model with concurrent assertions. */

`timescale 1ns/1ps

module tb_ahb_fir_slave;

  import fir_bus_pkg::*;

  // ****************************************
  // Run limits
  // ****************************************

  localparam int RESET_CYCLES = 8;
  // Six tests take about 100 bus cycles after reset
  localparam int MAX_CYCLES   = 400;
  localparam logic [31:0] LFSR_SEED = 32'd98422;

  // One transfer as the bus tasks issue it
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  byte_sz;
    logic [DATA_WIDTH-1:0] data;
  } xfer_t;

  // Bus side
  logic                  tb_clk;
  logic                  rst;
  logic                  hsel;
  logic [1:0]            htrans;
  logic [ADDR_WIDTH-1:0] haddr;
  logic                  hsize;
  logic                  hwrite;
  logic [DATA_WIDTH-1:0] hwdata;
  logic [DATA_WIDTH-1:0] hrdata;
  logic                  hresp;
  // Filter side
  logic [DATA_WIDTH-1:0] fir_out;
  logic                  modwait;
  logic                  err;
  logic [1:0]            coefficient_num;
  logic [DATA_WIDTH-1:0] sample_data;
  logic                  data_ready;
  logic [DATA_WIDTH-1:0] fir_coefficient;
  logic                  new_coefficient_set;

  // Register map model
  logic [15:0] exp_sample;
  logic [15:0] exp_coef [NUM_COEFFS];
  logic        exp_set;
  logic        exp_ready;
  logic        exp_hresp;
  logic        chk_rdata;
  logic [15:0] exp_rdata;
  logic [15:0] rdata_mask;
  logic [15:0] exp_fir_coef;
  // Transfers in flight
  xfer_t       aphase;
  xfer_t       dphase;
  // Filter inputs for the next bus cycle
  logic [1:0]  nxt_coef_num;
  logic        nxt_modwait;
  logic        nxt_err;
  logic [15:0] nxt_fir_out;

  logic [31:0] lfsr_state;
  string       cur_test;
  int          test_errors;
  int          error_count;
  int          tests_run;
  int          tests_passed;
  int          cycle_count;

  `include "tb_ahb_fir_tasks.svh"

  ahb_fir_slave i_ahb_fir_slave (
    .tb_clk              (tb_clk),
    .rst                 (rst),
    .hsel                (hsel),
    .htrans              (htrans),
    .haddr               (haddr),
    .hsize               (hsize),
    .hwrite              (hwrite),
    .hwdata              (hwdata),
    .hrdata              (hrdata),
    .hresp               (hresp),
    .fir_out             (fir_out),
    .modwait             (modwait),
    .err                 (err),
    .coefficient_num     (coefficient_num),
    .sample_data         (sample_data),
    .data_ready          (data_ready),
    .fir_coefficient     (fir_coefficient),
    .new_coefficient_set (new_coefficient_set)
  );

  // 100 ns period
  always #50 tb_clk = ~tb_clk;

  always @(posedge tb_clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ****************************************
  // Reporting
  // ****************************************

  task automatic mismatch(input string what, input logic [15:0] expected,
                          input logic [15:0] actual);
    test_errors++;
    error_count++;
    $display("Mismatch in %s: %s expected %h actual %h", cur_test, what, expected, actual);
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  // Drain the pipeline, then wait out the last checks
  task automatic end_test();
    idle_cycles(3);
    @(posedge tb_clk);
    #1;
    tests_run++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %s passed", cur_test);
    end else begin
      $display("Test %s failed with %0d mismatches", cur_test, test_errors);
    end
  endtask

  // ****************************************
  // Checks
  // ****************************************

  assign exp_fir_coef = exp_coef[coefficient_num];

  // Read data, only the lane the transfer takes
  assert property (@(posedge tb_clk) disable iff (rst)
    chk_rdata |-> ((hrdata & rdata_mask) === (exp_rdata & rdata_mask)))
    else mismatch("hrdata", $sampled(exp_rdata & rdata_mask), $sampled(hrdata & rdata_mask));

  // High exactly for the data phase of a bad transfer
  assert property (@(posedge tb_clk) disable iff (rst) hresp === exp_hresp)
    else mismatch("hresp", 16'($sampled(exp_hresp)), 16'($sampled(hresp)));

  assert property (@(posedge tb_clk) disable iff (rst) sample_data === exp_sample)
    else mismatch("sample_data", $sampled(exp_sample), $sampled(sample_data));

  assert property (@(posedge tb_clk) disable iff (rst) data_ready === exp_ready)
    else mismatch("data_ready", 16'($sampled(exp_ready)), 16'($sampled(data_ready)));

  assert property (@(posedge tb_clk) disable iff (rst) new_coefficient_set === exp_set)
    else mismatch("new_coefficient_set", 16'($sampled(exp_set)),
                  16'($sampled(new_coefficient_set)));

  assert property (@(posedge tb_clk) disable iff (rst) fir_coefficient === exp_fir_coef)
    else mismatch("fir_coefficient", $sampled(exp_fir_coef), $sampled(fir_coefficient));

  // Ends the run if the tests stall
  initial begin
    wait (cycle_count >= MAX_CYCLES);
    $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    int          a;
    logic [15:0] r;
    tb_clk          = 1'b0;
    rst             = 1'b1;
    hsel            = 1'b0;
    htrans          = 2'b00;
    haddr           = '0;
    hsize           = 1'b0;
    hwrite          = 1'b0;
    hwdata          = '0;
    fir_out         = '0;
    modwait         = 1'b0;
    err             = 1'b0;
    coefficient_num = 2'd0;
    exp_sample      = '0;
    for (a = 0; a < NUM_COEFFS; a++) begin
      exp_coef[a] = '0;
    end
    exp_set      = 1'b0;
    exp_ready    = 1'b0;
    exp_hresp    = 1'b0;
    chk_rdata    = 1'b0;
    exp_rdata    = '0;
    rdata_mask   = '0;
    aphase       = '0;
    dphase       = '0;
    stage_filter(2'd0, 1'b0, 1'b0, 16'h0000);
    lfsr_state   = LFSR_SEED;
    cycle_count  = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_passed = 0;
    repeat (RESET_CYCLES) @(negedge tb_clk);
    rst = 1'b0;

    // Everything zero, status and result follow the filter
    begin_test("reset_values");
    stage_filter(2'd0, 1'b1, 1'b1, random_bits(16));
    for (a = 0; a < 16; a += 2) begin
      read_half(4'(a));
    end
    end_test();

    // Write then read back to back, plus byte lanes
    begin_test("sample_write");
    write_half(ADDR_SAMPLE, random_bits(16));
    read_half(ADDR_SAMPLE);
    idle_cycles(1);
    write_byte(ADDR_SAMPLE + 4'd1, 8'(random_bits(8)));
    read_half(ADDR_SAMPLE);
    write_byte(ADDR_SAMPLE, 8'(random_bits(8)));
    read_byte(ADDR_SAMPLE + 4'd1);
    end_test();

    begin_test("coef_merge");
    for (a = 0; a < NUM_COEFFS; a++) begin
      write_half(4'(ADDR_COEF_START + 2 * a), random_bits(16));
    end
    write_byte(ADDR_COEF_START + 4'd1, 8'(random_bits(8)));
    write_byte(ADDR_COEF_START + 4'd4, 8'(random_bits(8)));
    write_byte(ADDR_COEF_START + 4'd7, 8'(random_bits(8)));
    for (a = 0; a < NUM_COEFFS; a++) begin
      read_half(4'(ADDR_COEF_START + 2 * a));
    end
    // Loader side select
    for (a = 0; a < NUM_COEFFS; a++) begin
      stage_filter(2'(a), 1'b1, 1'b0, nxt_fir_out);
      idle_cycles(1);
    end
    end_test();

    begin_test("status_result");
    repeat (4) begin
      r = random_bits(2);
      stage_filter(nxt_coef_num, r[0], r[1], random_bits(16));
      read_half(ADDR_STATUS);
      read_half(ADDR_RESULT);
      read_byte(ADDR_STATUS + 4'd1);
      read_byte(ADDR_RESULT + 4'd1);
    end
    end_test();

    // Each gives a one-cycle hresp and changes nothing
    begin_test("error_access");
    write_half(ADDR_STATUS, random_bits(16));
    write_half(ADDR_RESULT, random_bits(16));
    write_byte(4'd1, 8'(random_bits(8)));
    write_byte(4'd3, 8'(random_bits(8)));
    read_byte(4'd15);
    write_byte(4'd15, 8'(random_bits(8)));
    read_half(4'd5);
    write_half(4'd5, random_bits(16));
    write_half(4'd9, random_bits(16));
    read_half(ADDR_SAMPLE);
    for (a = 0; a < NUM_COEFFS; a++) begin
      read_half(4'(ADDR_COEF_START + 2 * a));
    end
    end_test();

    begin_test("coef_set");
    stage_filter(2'd0, 1'b1, 1'b0, nxt_fir_out);
    write_half(ADDR_COEF_SET, 16'h0001);
    read_half(ADDR_COEF_SET);
    // Flag holds while the filter is busy
    for (a = 1; a < NUM_COEFFS; a++) begin
      stage_filter(2'(a), 1'b1, 1'b0, nxt_fir_out);
      idle_cycles(1);
    end
    read_half(ADDR_COEF_SET);
    stage_filter(2'd3, 1'b0, 1'b0, nxt_fir_out);
    idle_cycles(1);
    read_half(ADDR_COEF_SET);
    stage_filter(2'd0, 1'b0, 1'b0, nxt_fir_out);
    write_byte(ADDR_COEF_SET, 8'h01);
    read_byte(ADDR_COEF_SET);
    write_half(ADDR_COEF_SET, 16'h0000);
    read_half(ADDR_COEF_SET);
    end_test();

    $display("Tests run %0d, passed %0d, failed %0d, mismatches %0d",
             tests_run, tests_passed, tests_run - tests_passed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
